//--- ucode_consts.svh
`ifndef UCODE_CONSTS_SVH
`define UCODE_CONSTS_SVH

//////////////////////////////
// Bus and buffer sizes
//////////////////////////////

// Byte address toward program memory
`define UC_ADDR_W 16

// Instruction byte buffer entries
`define UC_FIFO_DEPTH 4

//////////////////////////////
// Microcode sizes
//////////////////////////////

`define UC_FLOW_W 5
`define UC_ROM_SIZE 16

//////////////////////////////
// Z80 register codes
//////////////////////////////

// Code 6 is (HL), memory operand not supported here
`define UC_REG_B 3'd0
`define UC_REG_C 3'd1
`define UC_REG_D 3'd2
`define UC_REG_E 3'd3
`define UC_REG_H 3'd4
`define UC_REG_L 3'd5
`define UC_REG_A 3'd7

`endif

//--- ucode_pkg.sv
package ucode_pkg;

	//////////////////////////////
	// Instruction byte views
	//////////////////////////////

	// Opcode split as x:y:z, bits 7-6, 5-3, 2-0
	typedef struct packed {
		logic [1:0] x;
		logic [2:0] y;
		logic [2:0] z;
	} opFields_t;

	// Same byte, either an opcode or immediate data
	typedef union packed {
		opFields_t op;
		logic [7:0] data;
	} instrByte_u;

	//////////////////////////////
	// Micro-op encoding
	//////////////////////////////

	typedef enum logic [1:0] {
		SEQ_NEXT  = 2'd0,
		SEQ_FETCH = 2'd1,
		SEQ_EOF   = 2'd2
	} seqCtl_e;

	typedef enum logic [2:0] {
		UOP_NOP     = 3'd0,
		UOP_LOADIMM = 3'd1,
		UOP_INC     = 3'd2,
		UOP_DEC     = 3'd3,
		UOP_ADD     = 3'd4,
		UOP_SUB     = 3'd5
	} uopOp_e;

	// Operand register taken from opcode y or z field
	typedef enum logic {
		SEL_Y = 1'b0,
		SEL_Z = 1'b1
	} uopSel_e;

	typedef struct packed {
		seqCtl_e ctl;
		uopOp_e op;
		uopSel_e sel;
	} uopWord_t;

	//////////////////////////////
	// Stage interfaces
	//////////////////////////////

	typedef struct packed {
		logic valid;
		uopOp_e op;
		logic [2:0] regCode;
		logic [7:0] imm;
	} execReq_t;

	typedef struct packed {
		logic valid;
		logic [2:0] regCode;
		logic [7:0] data;
	} regWrite_t;

	typedef struct packed {
		logic valid;
		logic [7:0] opcode;
	} retire_t;

	typedef struct packed {
		logic z;
		logic c;
	} cpuFlags_t;

endpackage

//--- opcode_fetch.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module opcode_fetch
(
	input  logic clock,
	input  logic rstN,
	output logic [`UC_ADDR_W-1:0] wbAdr,
	input  logic [7:0] wbDat,
	output logic wbCyc,
	output logic wbStb,
	input  logic wbAck,
	output logic push,
	output logic [7:0] pushData,
	input  logic full
);

	// One outstanding read at a time
	logic reqActive;

	//////////////////////////////
	// Bus state machine
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			reqActive <= 1'b0;
			wbAdr <= '0;
		end
		else if (reqActive)
		begin
			// Transfer done, step to next program byte
			if (wbAck)
			begin
				reqActive <= 1'b0;
				wbAdr <= wbAdr + 1'b1;
			end
		end
		else if (!full)
		begin
			// Room left here stays, buffer only drains while in flight
			reqActive <= 1'b1;
		end
	end

	assign wbCyc = reqActive;
	assign wbStb = reqActive;

	// Acked byte goes straight into the buffer
	assign push = reqActive && wbAck;
	assign pushData = wbDat;

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Pending strobe keeps its address and stays up until ack
	holdAddr: assert property (
		@(posedge clock) disable iff (!rstN)
		(wbStb && !wbAck) |=> (wbStb && $stable(wbAdr))
	);

endmodule

//--- opcode_fifo.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module opcode_fifo import ucode_pkg::*;
(
	input  logic clock,
	input  logic rstN,
	input  logic push,
	input  logic [7:0] pushData,
	output logic full,
	input  logic pop,
	output instrByte_u popData,
	output logic empty
);

	localparam int PTR_W = $clog2(`UC_FIFO_DEPTH);
	localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`UC_FIFO_DEPTH - 1);

	logic [7:0] mem [`UC_FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0] count;

	// Entry storage
	always_ff @(posedge clock)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= (wrPtr == LAST_IDX) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == LAST_IDX) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Head entry shown directly
	assign popData = mem[rdPtr];
	assign full = (count == (PTR_W+1)'(`UC_FIFO_DEPTH));
	assign empty = (count == '0);

	noOverflow: assert property (@(posedge clock) disable iff (!rstN) push |-> !full);
	noUnderflow: assert property (@(posedge clock) disable iff (!rstN) pop |-> !empty);

endmodule

//--- ucode_rom.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module ucode_rom import ucode_pkg::*;
(
	input  instrByte_u opcode,
	output logic [`UC_FLOW_W-1:0] flowStart,
	input  logic [`UC_FLOW_W-1:0] uopAddr,
	output uopWord_t uop
);

	localparam logic [`UC_FLOW_W-1:0] FLOW_NOP = 5'd0;
	localparam logic [`UC_FLOW_W-1:0] FLOW_LDRN = 5'd1;
	localparam logic [`UC_FLOW_W-1:0] FLOW_INC = 5'd3;
	localparam logic [`UC_FLOW_W-1:0] FLOW_DEC = 5'd5;
	localparam logic [`UC_FLOW_W-1:0] FLOW_ADD = 5'd7;
	localparam logic [`UC_FLOW_W-1:0] FLOW_SUB = 5'd9;
	localparam logic [`UC_FLOW_W-1:0] FLOW_DEFAULT = 5'd11;

	//////////////////////////////
	// Opcode to flow index
	//////////////////////////////

	// One flow per operation, register comes from y or z
	always_comb
	begin
		flowStart = FLOW_DEFAULT;
		if (opcode.data == 8'h00)
			flowStart = FLOW_NOP;
		else if (opcode.op.x == 2'd0 && opcode.op.z == 3'd6)
			flowStart = FLOW_LDRN;
		else if (opcode.op.x == 2'd0 && opcode.op.z == 3'd4)
			flowStart = FLOW_INC;
		else if (opcode.op.x == 2'd0 && opcode.op.z == 3'd5)
			flowStart = FLOW_DEC;
		else if (opcode.op.x == 2'd2 && opcode.op.y == 3'd0)
			flowStart = FLOW_ADD;
		else if (opcode.op.x == 2'd2 && opcode.op.y == 3'd2)
			flowStart = FLOW_SUB;
	end

	//////////////////////////////
	// Micro-op words
	//////////////////////////////

	always_comb
	begin
		case (uopAddr)
			// NOP
			5'd0:  uop = '{SEQ_EOF,   UOP_NOP,     SEL_Y};
			// LD r,n, grab immediate then write it
			5'd1:  uop = '{SEQ_FETCH, UOP_NOP,     SEL_Y};
			5'd2:  uop = '{SEQ_EOF,   UOP_LOADIMM, SEL_Y};
			// INC r
			5'd3:  uop = '{SEQ_NEXT,  UOP_INC,     SEL_Y};
			5'd4:  uop = '{SEQ_EOF,   UOP_NOP,     SEL_Y};
			// DEC r
			5'd5:  uop = '{SEQ_NEXT,  UOP_DEC,     SEL_Y};
			5'd6:  uop = '{SEQ_EOF,   UOP_NOP,     SEL_Y};
			// ADD A,r
			5'd7:  uop = '{SEQ_NEXT,  UOP_ADD,     SEL_Z};
			5'd8:  uop = '{SEQ_EOF,   UOP_NOP,     SEL_Z};
			// SUB A,r
			5'd9:  uop = '{SEQ_NEXT,  UOP_SUB,     SEL_Z};
			5'd10: uop = '{SEQ_EOF,   UOP_NOP,     SEL_Z};
			// Anything else just retires
			5'd11: uop = '{SEQ_NEXT,  UOP_NOP,     SEL_Y};
			5'd12: uop = '{SEQ_EOF,   UOP_NOP,     SEL_Y};
			default: uop = '{SEQ_EOF, UOP_NOP,     SEL_Y};
		endcase
	end

endmodule

//--- ucode_seq.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module ucode_seq import ucode_pkg::*;
(
	input  logic clock,
	input  logic rstN,
	input  logic empty,
	input  instrByte_u popData,
	output logic pop,
	output execReq_t execReq,
	output retire_t retire
);

	logic busy;
	logic [`UC_FLOW_W-1:0] upc;
	logic [`UC_FLOW_W-1:0] flowStart;
	instrByte_u opLatch;
	logic [7:0] immLatch;
	uopWord_t uop;
	logic fetchStep;
	logic stall;
	logic step;

	// Decode sees the buffer head, ROM sees the running flow
	ucode_rom u_ucode_rom
	(
		.opcode(popData),
		.flowStart(flowStart),
		.uopAddr(upc),
		.uop(uop)
	);

	//////////////////////////////
	// Step control
	//////////////////////////////

	assign fetchStep = busy && (uop.ctl == SEQ_FETCH);
	// Immediate not here yet, hold current micro-op
	assign stall = fetchStep && empty;
	assign step = busy && !stall;

	// Opcode when idle, immediate on a fetch step
	assign pop = !empty && (!busy || fetchStep);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			upc <= '0;
		end
		else if (!busy)
		begin
			if (!empty)
			begin
				busy <= 1'b1;
				upc <= flowStart;
			end
		end
		else if (step)
		begin
			if (uop.ctl == SEQ_EOF)
				busy <= 1'b0;
			else
				upc <= upc + 1'b1;
		end
	end

	// Opcode and immediate holding registers
	always_ff @(posedge clock)
	begin
		if (!busy && !empty)
			opLatch <= popData;
		if (fetchStep && !empty)
			immLatch <= popData.data;
	end

	//////////////////////////////
	// Requests and retire
	//////////////////////////////

	always_comb
	begin
		execReq.valid = step && (uop.op != UOP_NOP);
		execReq.op = uop.op;
		execReq.regCode = (uop.sel == SEL_Y) ? opLatch.op.y : opLatch.op.z;
		execReq.imm = immLatch;
	end

	assign retire.valid = step && (uop.ctl == SEQ_EOF);
	assign retire.opcode = opLatch.data;

	// Every flow ends inside the ROM
	upcInRange: assert property (
		@(posedge clock) disable iff (!rstN)
		upc < `UC_ROM_SIZE
	);

endmodule

//--- ucode_exec.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module ucode_exec import ucode_pkg::*;
(
	input  logic clock,
	input  logic rstN,
	input  execReq_t execReq,
	output regWrite_t regWrite,
	output cpuFlags_t flags
);

	logic [7:0] regs [8];
	logic [7:0] srcVal;
	logic [7:0] accVal;
	logic [8:0] sum9;
	logic [8:0] diff9;
	logic wrEn;
	logic [2:0] wrCode;
	logic [7:0] wrData;
	cpuFlags_t nextFlags;

	// Real registers only, (HL) is ignored
	function automatic logic isGpr(input logic [2:0] code);
		return code inside {`UC_REG_B, `UC_REG_C, `UC_REG_D, `UC_REG_E,
			`UC_REG_H, `UC_REG_L, `UC_REG_A};
	endfunction

	//////////////////////////////
	// ALU
	//////////////////////////////

	assign srcVal = regs[execReq.regCode];
	assign accVal = regs[`UC_REG_A];
	assign sum9 = {1'b0, accVal} + {1'b0, srcVal};
	// Bit 8 set on borrow
	assign diff9 = {1'b0, accVal} - {1'b0, srcVal};

	always_comb
	begin
		wrEn = 1'b0;
		wrCode = execReq.regCode;
		wrData = execReq.imm;
		nextFlags = flags;
		if (execReq.valid && isGpr(execReq.regCode))
		begin
			wrEn = 1'b1;
			case (execReq.op)
				UOP_LOADIMM: wrData = execReq.imm;
				UOP_INC: wrData = srcVal + 8'd1;
				UOP_DEC: wrData = srcVal - 8'd1;
				UOP_ADD:
				begin
					wrCode = `UC_REG_A;
					wrData = sum9[7:0];
					nextFlags.c = sum9[8];
				end
				UOP_SUB:
				begin
					wrCode = `UC_REG_A;
					wrData = diff9[7:0];
					nextFlags.c = diff9[8];
				end
				default: wrEn = 1'b0;
			endcase
			// Z follows every arithmetic result
			if (execReq.op != UOP_LOADIMM && wrEn)
				nextFlags.z = (wrData == 8'h00);
		end
	end

	//////////////////////////////
	// Register file and flags
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= 8'h00;
			flags <= '0;
			regWrite <= '0;
		end
		else
		begin
			if (wrEn)
				regs[wrCode] <= wrData;
			flags <= nextFlags;
			regWrite.valid <= wrEn;
			regWrite.regCode <= wrCode;
			regWrite.data <= wrData;
		end
	end

endmodule

//--- dzcpu_core.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module dzcpu_core import ucode_pkg::*;
(
	input  logic clock,
	input  logic rstN,
	output logic [`UC_ADDR_W-1:0] wbAdr,
	input  logic [7:0] wbDat,
	output logic wbCyc,
	output logic wbStb,
	input  logic wbAck,
	output regWrite_t regWrite,
	output cpuFlags_t flags,
	output retire_t retire
);

	logic push;
	logic [7:0] pushData;
	logic full;
	logic pop;
	instrByte_u popData;
	logic empty;
	execReq_t execReq;

	opcode_fetch u_opcode_fetch
	(
		.clock(clock),
		.rstN(rstN),
		.wbAdr(wbAdr),
		.wbDat(wbDat),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck),
		.push(push),
		.pushData(pushData),
		.full(full)
	);

	opcode_fifo u_opcode_fifo
	(
		.clock(clock),
		.rstN(rstN),
		.push(push),
		.pushData(pushData),
		.full(full),
		.pop(pop),
		.popData(popData),
		.empty(empty)
	);

	ucode_seq u_ucode_seq
	(
		.clock(clock),
		.rstN(rstN),
		.empty(empty),
		.popData(popData),
		.pop(pop),
		.execReq(execReq),
		.retire(retire)
	);

	ucode_exec u_ucode_exec
	(
		.clock(clock),
		.rstN(rstN),
		.execReq(execReq),
		.regWrite(regWrite),
		.flags(flags)
	);

endmodule

//--- tb_dzcpu.sv
`timescale 1ns/1ps
`include "ucode_consts.svh"

module tb_dzcpu import ucode_pkg::*;
();

	logic clock;
	logic rstN;
	logic [`UC_ADDR_W-1:0] wbAdr;
	logic [7:0] wbDat;
	logic wbCyc;
	logic wbStb;
	logic wbAck;
	regWrite_t regWrite;
	cpuFlags_t flags;
	retire_t retire;

	logic [7:0] progMem [256];
	logic [7:0] progQ [$];
	logic [7:0] expRetire [$];
	// Packed as flags z and c, then register code, then data
	logic [12:0] expWrite [$];
	logic expZ;
	logic expC;
	int retireIdx;
	int writeIdx;
	int passCount;
	int failCount;
	int testErrors;
	logic testActive = 1'b0;
	time deadline = 0;
	string testName;
	logic [31:0] rngState;
	int delayLeft;
	logic delayArmed;
	logic [`UC_ADDR_W-1:0] fetchAddr;

	dzcpu_core u_dzcpu_core
	(
		.clock(clock),
		.rstN(rstN),
		.wbAdr(wbAdr),
		.wbDat(wbDat),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck),
		.regWrite(regWrite),
		.flags(flags),
		.retire(retire)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic checkValue(input string sigName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, sigName,
				expected, actual);
			failCount++;
			testErrors++;
		end
		else
			passCount++;
	endtask

	// First byte sits in the most significant position of the n-byte window
	task automatic appendBytes(input logic [63:0] bytes, input int n);
		int k;
		for (k = 0; k < n; k++)
			progQ.push_back(bytes[8*(n-1-k) +: 8]);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Walks the program with the instruction rules starting from reset state
	function automatic void buildExpected(input int nBytes);
		logic [7:0] regs [8];
		logic [7:0] op;
		logic [7:0] val;
		logic [7:0] acc;
		int pc;
		int i;
		expRetire.delete();
		expWrite.delete();
		expZ = 1'b0;
		expC = 1'b0;
		for (i = 0; i < 8; i++)
			regs[i] = 8'h00;
		pc = 0;
		while (pc < nBytes)
		begin
			op = progMem[pc];
			pc++;
			expRetire.push_back(op);
			acc = regs[`UC_REG_A];
			if (op == 8'h00)
				continue;
			if (op[7:6] == 2'd0 && op[2:0] == 3'd6)
			begin
				// LD r,n takes the following byte as data
				val = progMem[pc];
				pc++;
				if (op[5:3] != 3'd6)
				begin
					regs[op[5:3]] = val;
					expWrite.push_back({expZ, expC, op[5:3], val});
				end
			end
			else if (op[7:6] == 2'd0 && (op[2:0] == 3'd4 || op[2:0] == 3'd5) && op[5:3] != 3'd6)
			begin
				val = (op[2:0] == 3'd4) ? regs[op[5:3]] + 8'd1 : regs[op[5:3]] - 8'd1;
				regs[op[5:3]] = val;
				expZ = (val == 8'h00);
				expWrite.push_back({expZ, expC, op[5:3], val});
			end
			else if (op[7:6] == 2'd2 && (op[5:3] == 3'd0 || op[5:3] == 3'd2) && op[2:0] != 3'd6)
			begin
				if (op[5:3] == 3'd0)
				begin
					val = acc + regs[op[2:0]];
					expC = (int'(acc) + int'(regs[op[2:0]])) > 255;
				end
				else
				begin
					val = acc - regs[op[2:0]];
					expC = acc < regs[op[2:0]];
				end
				regs[`UC_REG_A] = val;
				expZ = (val == 8'h00);
				expWrite.push_back({expZ, expC, `UC_REG_A, val});
			end
		end
	endfunction

	//////////////////////////////
	// Memory and compare
	//////////////////////////////

	// Program memory with an ack wait of 0 to 3 cycles per request
	always @(negedge clock)
	begin
		if (!rstN || !wbStb || wbAck)
		begin
			wbAck = 1'b0;
			delayArmed = 1'b0;
			if (!rstN)
				fetchAddr = '0;
		end
		else
		begin
			if (!delayArmed)
			begin
				delayLeft = int'(nextRand() % 4);
				delayArmed = 1'b1;
			end
			if (delayLeft == 0)
			begin
				// Fetch addresses run upward from 0 with no gaps
				checkValue("wbAdr", 32'(fetchAddr), 32'(wbAdr));
				fetchAddr++;
				wbAck = 1'b1;
				wbDat = progMem[wbAdr[7:0]];
			end
			else
				delayLeft--;
		end
	end

	// Retires past the expected list are trailing NOP fill
	always @(negedge clock)
	begin
		if (testActive)
		begin
			if (retire.valid && retireIdx < expRetire.size())
			begin
				checkValue("retire.opcode", 32'(expRetire[retireIdx]), 32'(retire.opcode));
				retireIdx++;
			end
			if (regWrite.valid)
			begin
				if (writeIdx < expWrite.size())
				begin
					checkValue("regWrite.regCode", 32'(expWrite[writeIdx][10:8]),
						32'(regWrite.regCode));
					checkValue("regWrite.data", 32'(expWrite[writeIdx][7:0]),
						32'(regWrite.data));
					checkValue("flags", 32'(expWrite[writeIdx][12:11]), 32'(flags));
				end
				else
				begin
					$display("t=%0t register write to code %0d that the program does not make",
						$time, regWrite.regCode);
					failCount++;
					testErrors++;
				end
				writeIdx++;
			end
		end
	end

	initial
	begin
		while (deadline == 0 || $time <= deadline)
			@(negedge clock);
		$display("Test %s hung with %0d of %0d instructions retired", testName,
			retireIdx, expRetire.size());
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	task automatic runProgram(input string name);
		int i;
		int len;
		len = progQ.size();
		for (i = 0; i < 256; i++)
			progMem[i] = (i < len) ? progQ[i] : 8'h00;
		buildExpected(len);
		testName = name;
		testErrors = 0;
		retireIdx = 0;
		writeIdx = 0;
		deadline = $time + 20 * (40 * len + 16 + 8);
		@(negedge clock);
		rstN = 1'b0;
		repeat (16)
		begin
			@(negedge clock);
			checkValue("wbCyc", 0, 32'(wbCyc));
			checkValue("wbStb", 0, 32'(wbStb));
			checkValue("regWrite.valid", 0, 32'(regWrite.valid));
			checkValue("retire.valid", 0, 32'(retire.valid));
		end
		checkValue("flags", 0, 32'(flags));
		rstN = 1'b1;
		testActive = 1'b1;
		@(negedge clock);
		checkValue("regWrite.valid", 0, 32'(regWrite.valid));
		checkValue("retire.valid", 0, 32'(retire.valid));
		while (retireIdx < expRetire.size())
			@(posedge clock);
		// Last register write lands one cycle after its request
		repeat (4) @(negedge clock);
		checkValue("write count", 32'(expWrite.size()), 32'(writeIdx));
		checkValue("flags", 32'({expZ, expC}), 32'(flags));
		@(posedge clock);
		testActive = 1'b0;
		deadline = 0;
		if (testErrors == 0)
			$display("test %s ok, %0d instructions", name, expRetire.size());
		else
			$display("test %s had %0d errors", name, testErrors);
	endtask

	initial
	begin
		logic [31:0] r;
		logic [2:0] code;
		int i;
		rstN = 1'b0;
		wbAck = 1'b0;
		wbDat = 8'h00;
		delayArmed = 1'b0;
		delayLeft = 0;
		fetchAddr = '0;
		rngState = 32'h7c1314bc;
		passCount = 0;
		failCount = 0;

		// LD r,n for every register with A last
		progQ.delete();
		for (i = 0; i < 8; i++)
		begin
			if (i != 6)
			begin
				progQ.push_back(8'(i * 8 + 6));
				progQ.push_back(8'(8'h5a ^ (i * 37)));
			end
		end
		runProgram("reset and immediate loads");

		// ADD sets carry first and INC/DEC then wrap through 0 and 255
		progQ.delete();
		appendBytes(64'h3ef0_1620_8206_ff04, 8);
		appendBytes(64'h050e_010d_0d0c_3c2d, 8);
		runProgram("inc and dec");

		// Includes ADD A,A and SUB A,A
		progQ.delete();
		appendBytes(64'h3e80_873e_101e_2093, 8);
		appendBytes(64'h9726_0584_953e_ff06, 8);
		appendBytes(64'h0180_90, 3);
		runProgram("add and sub");

		// HALT, CB, (HL) forms and other unsupported opcodes
		progQ.delete();
		appendBytes(64'h0076_cb34_3586_9607, 8);
		appendBytes(64'h3e09_083f_2700_c904, 8);
		runProgram("nop and undecoded");

		// Random 200 instructions with LD only while its bytes still fit
		progQ.delete();
		for (i = 0; i < 200; i++)
		begin
			r = nextRand();
			code = (r[10:8] == 3'd6) ? `UC_REG_A : r[10:8];
			if (r[2:0] == 3'd1 && progQ.size() + 201 - i <= 250)
			begin
				progQ.push_back({2'b00, code, 3'd6});
				progQ.push_back(r[23:16]);
			end
			else if (r[2:0] == 3'd2)
				progQ.push_back({2'b00, code, 3'd4});
			else if (r[2:0] == 3'd3)
				progQ.push_back({2'b00, code, 3'd5});
			else if (r[2:1] == 2'd2)
				progQ.push_back({2'b10, 3'd0, code});
			else if (r[2:1] == 2'd3)
				progQ.push_back({2'b10, 3'd2, code});
			else
				progQ.push_back(8'h00);
		end
		runProgram("random program");

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
ucode_pkg.sv
opcode_fetch.sv
opcode_fifo.sv
ucode_rom.sv
ucode_seq.sv
ucode_exec.sv
dzcpu_core.sv
tb_dzcpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dzcpu -f list.f -o sim_dzcpu
./obj_dir/sim_dzcpu | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
